// File: regfile_pkg.sv
// Register file control definitions
`default_nettype none

package regfile_pkg;

  // Bus geometry
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = 4;

  // Job contexts and per-context parameter words
  localparam int unsigned N_CONTEXT   = 2;
  localparam int unsigned LOG_CONTEXT = 1;
  localparam int unsigned N_IO_REGS   = 4;
  localparam int unsigned LOG_IO_REGS = 2;

  // Word address is context bits above the register index
  localparam int unsigned LOG_REGS         = 5;
  localparam int unsigned ADDR_WIDTH       = LOG_REGS + LOG_CONTEXT;
  localparam int unsigned N_MANDATORY_REGS = 8;

  localparam int unsigned JOB_ID_WIDTH     = 8;
  localparam int unsigned STORE_ADDR_WIDTH = 3;
  localparam int unsigned N_STORE_WORDS    = N_CONTEXT * N_IO_REGS;
  localparam int unsigned FINISHED_WIDTH   = 2;

  // First parameter index and context stride in store words
  localparam logic [LOG_REGS-1:0]         PARAM_BASE = LOG_REGS'(N_MANDATORY_REGS);
  localparam logic [STORE_ADDR_WIDTH-1:0] IO_STRIDE  = STORE_ADDR_WIDTH'(N_IO_REGS);

  // Mandatory register map
  localparam logic [LOG_REGS-1:0] REG_TRIGGER   = 5'd0; // Write starts the acquired job
  localparam logic [LOG_REGS-1:0] REG_ACQUIRE   = 5'd1; // Test-and-set read
  localparam logic [LOG_REGS-1:0] REG_FINISHED  = 5'd2; // Write clears
  localparam logic [LOG_REGS-1:0] REG_STATUS    = 5'd3;
  localparam logic [LOG_REGS-1:0] REG_RUNNING   = 5'd4;
  localparam logic [LOG_REGS-1:0] REG_SOFTCLEAR = 5'd5;

  // Acquire responses
  localparam logic [DATA_WIDTH-1:0] RESP_LOCKED   = 32'hFFFF_FFFE;
  localparam logic [DATA_WIDTH-1:0] RESP_ALL_BUSY = 32'hFFFF_FFFF;
  localparam logic [DATA_WIDTH-1:0] RESP_UNMAPPED = 32'hFFFF_0000;

  localparam logic [FINISHED_WIDTH-1:0] FINISHED_MAX = 2'd2;
  localparam logic [7:0]                STATUS_BUSY  = 8'h01; // Busy byte of one context

  // Source of the registered read return
  localparam int unsigned RD_SEL_WIDTH = 2;
  localparam logic [RD_SEL_WIDTH-1:0] RD_NONE    = 2'd0;
  localparam logic [RD_SEL_WIDTH-1:0] RD_ACQUIRE = 2'd1;
  localparam logic [RD_SEL_WIDTH-1:0] RD_MAND    = 2'd2;
  localparam logic [RD_SEL_WIDTH-1:0] RD_STORE   = 2'd3;

  // Bus word address seen as a plain index or as context plus index
  typedef union packed {
    struct packed {
      logic [LOG_CONTEXT-1:0] pad; // Ignored for mandatory registers
      logic [LOG_REGS-1:0]    idx;
    } mand;
    struct packed {
      logic [LOG_CONTEXT-1:0] ctx;
      logic [LOG_REGS-1:0]    idx;
    } ctx;
  } regfile_addr_u;

endpackage

`default_nettype wire

// File: regfile_access_decode.sv
// Register bus access decoder
`timescale 1ns/1ps
`default_nettype none

module regfile_access_decode (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic                                      wen_i,
  input  regfile_pkg::regfile_addr_u                addr_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]        wdata_i,
  input  logic [regfile_pkg::BE_WIDTH-1:0]          be_i,
  input  logic                                      pointer_busy_i,
  input  logic                                      clear_i,
  output logic                                      trigger_o,
  output logic                                      acquire_ok_o,
  output logic                                      finished_clr_o,
  output logic                                      soft_clear_o,
  output logic [regfile_pkg::RD_SEL_WIDTH-1:0]      rd_sel_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]        resp_o,
  output logic [regfile_pkg::LOG_CONTEXT-1:0]       pointer_ctx_o,
  output logic                                      st_we_o,
  output logic                                      st_re_o,
  output logic [regfile_pkg::STORE_ADDR_WIDTH-1:0]  st_addr_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]        st_wdata_o,
  output logic [regfile_pkg::BE_WIDTH-1:0]          st_be_o
);

  logic                                     rd_req;
  logic                                     wr_req;
  logic                                     is_mand;
  logic                                     acq_req;
  logic                                     acq_grant;
  logic                                     trig_wr;
  logic [regfile_pkg::LOG_REGS-1:0]         param_off;
  logic [regfile_pkg::LOG_IO_REGS-1:0]      io_off;
  logic [regfile_pkg::STORE_ADDR_WIDTH-1:0] ctx_base;
  logic [regfile_pkg::RD_SEL_WIDTH-1:0]     rd_sel_d;
  logic [regfile_pkg::DATA_WIDTH-1:0]       resp_d;
  logic                                     lock_q;
  logic [regfile_pkg::JOB_ID_WIDTH-1:0]     job_id_q;

  assign rd_req  = req_i & ~wen_i;
  assign wr_req  = req_i & wen_i;
  assign is_mand = addr_i.mand.idx < regfile_pkg::PARAM_BASE;

  assign acq_req   = rd_req & is_mand & (addr_i.mand.idx == regfile_pkg::REG_ACQUIRE);
  assign acq_grant = acq_req & ~lock_q & ~pointer_busy_i; // Job id handed out
  assign trig_wr   = wr_req & is_mand & (addr_i.mand.idx == regfile_pkg::REG_TRIGGER);

  // Parameter word inside the store
  assign param_off = addr_i.ctx.idx - regfile_pkg::PARAM_BASE;
  assign io_off    = param_off[regfile_pkg::LOG_IO_REGS-1:0];
  assign ctx_base  = addr_i.ctx.ctx * regfile_pkg::IO_STRIDE;

  assign st_we_o    = wr_req & ~is_mand;
  assign st_re_o    = rd_req & ~is_mand;
  assign st_addr_o  = ctx_base + io_off;
  assign st_wdata_o = wdata_i;
  assign st_be_o    = be_i;

  assign pointer_ctx_o = job_id_q[regfile_pkg::LOG_CONTEXT-1:0]; // Context of the next offload

  // Read source and response word
  always_comb begin
    rd_sel_d = regfile_pkg::RD_NONE;
    resp_d   = '0;
    if (acq_req) begin
      rd_sel_d = regfile_pkg::RD_ACQUIRE;
      if (lock_q) begin
        resp_d = regfile_pkg::RESP_LOCKED;
      end else if (pointer_busy_i) begin
        resp_d = regfile_pkg::RESP_ALL_BUSY;
      end else begin
        resp_d[regfile_pkg::JOB_ID_WIDTH-1:0] = job_id_q;
      end
    end else if (rd_req && is_mand) begin
      rd_sel_d = regfile_pkg::RD_MAND;
      resp_d[regfile_pkg::LOG_REGS-1:0] = addr_i.mand.idx; // Index for the tracker mux
    end else if (rd_req) begin
      rd_sel_d = regfile_pkg::RD_STORE;
    end
  end

  // Strobes to the tracker, one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trigger_o      <= 1'b0;
      acquire_ok_o   <= 1'b0;
      finished_clr_o <= 1'b0;
      soft_clear_o   <= 1'b0;
      rd_sel_o       <= regfile_pkg::RD_NONE;
    end else begin
      trigger_o      <= trig_wr;
      acquire_ok_o   <= acq_grant;
      finished_clr_o <= wr_req & is_mand & (addr_i.mand.idx == regfile_pkg::REG_FINISHED);
      soft_clear_o   <= wr_req & is_mand & (addr_i.mand.idx == regfile_pkg::REG_SOFTCLEAR);
      rd_sel_o       <= rd_sel_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      resp_o <= resp_d;
    end
  end

  // Offload lock and job id
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q   <= 1'b0;
      job_id_q <= '0;
    end else if (clear_i) begin
      lock_q   <= 1'b0;
      job_id_q <= '0;
    end else if (acq_grant) begin
      lock_q   <= 1'b1;
      job_id_q <= job_id_q + 1'b1;
    end else if (trig_wr) begin
      lock_q <= 1'b0; // Offloader is done programming
    end
  end

endmodule

`default_nettype wire

// File: regfile_param_store.sv
// Per-context parameter store
`timescale 1ns/1ps
`default_nettype none

module regfile_param_store (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         clear_i,
  input  logic                                         we_i,
  input  logic                                         re_i,
  input  logic [regfile_pkg::STORE_ADDR_WIDTH-1:0]     addr_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]           wdata_i,
  input  logic [regfile_pkg::BE_WIDTH-1:0]             be_i,
  input  logic [regfile_pkg::LOG_CONTEXT-1:0]          running_ctx_i,
  output logic [regfile_pkg::DATA_WIDTH-1:0]           rdata_o,
  output logic [regfile_pkg::N_IO_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] params_o
);

  // Context c owns words c*N_IO_REGS up to c*N_IO_REGS+N_IO_REGS-1
  logic [regfile_pkg::N_STORE_WORDS-1:0][regfile_pkg::DATA_WIDTH-1:0] mem_q;

  // Byte-wise write port
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else if (we_i) begin
      for (int b = 0; b < regfile_pkg::BE_WIDTH; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  // Engine view of the running context
  always_comb begin
    for (int w = 0; w < regfile_pkg::N_IO_REGS; w++) begin
      params_o[w] = mem_q[running_ctx_i * regfile_pkg::N_IO_REGS + w];
    end
  end

endmodule

`default_nettype wire

// File: regfile_job_tracker.sv
// Job context tracker
`timescale 1ns/1ps
`default_nettype none

module regfile_job_tracker (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  trigger_i,
  input  logic                                  acquire_ok_i,
  input  logic                                  finished_clr_i,
  input  logic                                  soft_clear_i,
  input  logic                                  done_i,
  input  logic [regfile_pkg::RD_SEL_WIDTH-1:0]  rd_sel_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    resp_i,
  input  logic [regfile_pkg::LOG_CONTEXT-1:0]   pointer_ctx_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]    store_rdata_i,
  output logic                                  pointer_busy_o,
  output logic [regfile_pkg::LOG_CONTEXT-1:0]   running_ctx_o,
  output logic                                  busy_o,
  output logic [regfile_pkg::DATA_WIDTH-1:0]    rdata_o
);

  logic [regfile_pkg::N_CONTEXT-1:0][7:0]     status_q;
  logic [regfile_pkg::LOG_CONTEXT-1:0]        acq_ctx_q;
  logic [regfile_pkg::JOB_ID_WIDTH-1:0]       running_id_q;
  logic [regfile_pkg::FINISHED_WIDTH-1:0]     finished_q;
  logic [regfile_pkg::DATA_WIDTH-1:0]         status_word;
  logic [regfile_pkg::DATA_WIDTH-1:0]         mand_rdata;

  assign running_ctx_o  = running_id_q[regfile_pkg::LOG_CONTEXT-1:0];
  assign pointer_busy_o = |status_q[pointer_ctx_i];
  assign busy_o         = |status_q;

  // Context granted by the last acquire comes from the job id in the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acq_ctx_q <= '0;
    end else if (soft_clear_i) begin
      acq_ctx_q <= '0;
    end else if (acquire_ok_i) begin
      acq_ctx_q <= resp_i[regfile_pkg::LOG_CONTEXT-1:0];
    end
  end

  // Busy byte per context
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else if (soft_clear_i) begin
      status_q <= '0;
    end else begin
      for (int c = 0; c < regfile_pkg::N_CONTEXT; c++) begin
        if (trigger_i && (acq_ctx_q == c)) begin
          status_q[c] <= regfile_pkg::STATUS_BUSY;
        end else if (done_i && (running_ctx_o == c)) begin
          status_q[c] <= '0; // Engine finished this context
        end
      end
    end
  end

  // Running job id follows the engine
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_id_q <= '0;
    end else if (soft_clear_i) begin
      running_id_q <= '0;
    end else if (done_i) begin
      running_id_q <= running_id_q + 1'b1;
    end
  end

  // Finished jobs, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= '0;
    end else if (soft_clear_i || finished_clr_i) begin
      finished_q <= '0;
    end else if (done_i && (finished_q < regfile_pkg::FINISHED_MAX)) begin
      finished_q <= finished_q + 1'b1;
    end
  end

  // First context in the low byte
  always_comb begin
    status_word = '0;
    for (int c = 0; c < regfile_pkg::N_CONTEXT; c++) begin
      status_word[c*8 +: 8] = status_q[c];
    end
  end

  // Mandatory register read by the registered index
  always_comb begin
    mand_rdata = regfile_pkg::RESP_UNMAPPED;
    case (resp_i[regfile_pkg::LOG_REGS-1:0])
      regfile_pkg::REG_STATUS: begin
        mand_rdata = status_word;
      end
      regfile_pkg::REG_FINISHED: begin
        mand_rdata = '0;
        mand_rdata[regfile_pkg::FINISHED_WIDTH-1:0] = finished_q;
      end
      regfile_pkg::REG_RUNNING: begin
        mand_rdata = '0;
        mand_rdata[regfile_pkg::JOB_ID_WIDTH-1:0] = running_id_q;
      end
      regfile_pkg::REG_TRIGGER, regfile_pkg::REG_SOFTCLEAR: begin
        mand_rdata = '0; // Write-only registers
      end
      default: begin
        mand_rdata = regfile_pkg::RESP_UNMAPPED;
      end
    endcase
  end

  // Read return
  always_comb begin
    case (rd_sel_i)
      regfile_pkg::RD_ACQUIRE: rdata_o = resp_i;
      regfile_pkg::RD_MAND:    rdata_o = mand_rdata;
      regfile_pkg::RD_STORE:   rdata_o = store_rdata_i;
      default:                 rdata_o = '0; // No read in flight
    endcase
  end

endmodule

`default_nettype wire

// File: regfile_ctrl_top.sv
// Register file control top level
`timescale 1ns/1ps
`default_nettype none

module regfile_ctrl_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      req_i,
  input  logic                                      wen_i,
  input  logic [regfile_pkg::ADDR_WIDTH-1:0]        addr_i,
  input  logic [regfile_pkg::DATA_WIDTH-1:0]        wdata_i,
  input  logic [regfile_pkg::BE_WIDTH-1:0]          be_i,
  input  logic                                      done_i,
  output logic [regfile_pkg::DATA_WIDTH-1:0]        rdata_o,
  output logic [regfile_pkg::N_IO_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] params_o,
  output logic [regfile_pkg::LOG_CONTEXT-1:0]       running_ctx_o,
  output logic                                      busy_o
);

  // Decoder to tracker
  logic                                     trigger;
  logic                                     acquire_ok;
  logic                                     finished_clr;
  logic                                     soft_clear;
  logic [regfile_pkg::RD_SEL_WIDTH-1:0]     rd_sel;
  logic [regfile_pkg::DATA_WIDTH-1:0]       resp;
  logic [regfile_pkg::LOG_CONTEXT-1:0]      pointer_ctx;
  logic                                     pointer_busy;

  // Decoder to store
  logic                                     st_we;
  logic                                     st_re;
  logic [regfile_pkg::STORE_ADDR_WIDTH-1:0] st_addr;
  logic [regfile_pkg::DATA_WIDTH-1:0]       st_wdata;
  logic [regfile_pkg::BE_WIDTH-1:0]         st_be;
  logic [regfile_pkg::DATA_WIDTH-1:0]       st_rdata;

  regfile_access_decode i_decode (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .req_i          ( req_i        ),
    .wen_i          ( wen_i        ),
    .addr_i         ( addr_i       ),
    .wdata_i        ( wdata_i      ),
    .be_i           ( be_i         ),
    .pointer_busy_i ( pointer_busy ),
    .clear_i        ( soft_clear   ),
    .trigger_o      ( trigger      ),
    .acquire_ok_o   ( acquire_ok   ),
    .finished_clr_o ( finished_clr ),
    .soft_clear_o   ( soft_clear   ),
    .rd_sel_o       ( rd_sel       ),
    .resp_o         ( resp         ),
    .pointer_ctx_o  ( pointer_ctx  ),
    .st_we_o        ( st_we        ),
    .st_re_o        ( st_re        ),
    .st_addr_o      ( st_addr      ),
    .st_wdata_o     ( st_wdata     ),
    .st_be_o        ( st_be        )
  );

  regfile_param_store i_store (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( soft_clear    ),
    .we_i          ( st_we         ),
    .re_i          ( st_re         ),
    .addr_i        ( st_addr       ),
    .wdata_i       ( st_wdata      ),
    .be_i          ( st_be         ),
    .running_ctx_i ( running_ctx_o ),
    .rdata_o       ( st_rdata      ),
    .params_o      ( params_o      )
  );

  regfile_job_tracker i_tracker (
    .clk_i          ( clk_i         ),
    .rst_ni         ( rst_ni        ),
    .trigger_i      ( trigger       ),
    .acquire_ok_i   ( acquire_ok    ),
    .finished_clr_i ( finished_clr  ),
    .soft_clear_i   ( soft_clear    ),
    .done_i         ( done_i        ),
    .rd_sel_i       ( rd_sel        ),
    .resp_i         ( resp          ),
    .pointer_ctx_i  ( pointer_ctx   ),
    .store_rdata_i  ( st_rdata      ),
    .pointer_busy_o ( pointer_busy  ),
    .running_ctx_o  ( running_ctx_o ),
    .busy_o         ( busy_o        ),
    .rdata_o        ( rdata_o       )
  );

endmodule

`default_nettype wire

// File: tb_regfile_ctrl_model.svh
// Register file reference model
`ifndef TB_REGFILE_CTRL_MODEL_SVH
`define TB_REGFILE_CTRL_MODEL_SVH

logic [regfile_pkg::DATA_WIDTH-1:0]   mdl_mem [regfile_pkg::N_CONTEXT * regfile_pkg::N_IO_REGS];
logic                                 mdl_busy [regfile_pkg::N_CONTEXT];
logic                                 mdl_lock;
logic [regfile_pkg::JOB_ID_WIDTH-1:0] mdl_job_id;   // Next offload id
logic [regfile_pkg::JOB_ID_WIDTH-1:0] mdl_run_id;
int unsigned                          mdl_acq_ctx;  // Context of the last granted acquire
int unsigned                          mdl_finished;

function automatic void model_clear();
  foreach (mdl_mem[i])
    mdl_mem[i] = '0;
  foreach (mdl_busy[c])
    mdl_busy[c] = 1'b0;
  mdl_lock     = 1'b0;
  mdl_job_id   = '0;
  mdl_run_id   = '0;
  mdl_acq_ctx  = 0;
  mdl_finished = 0;
endfunction

// Context word block followed by the offset above the mandatory region
function automatic int unsigned store_word(logic [regfile_pkg::ADDR_WIDTH-1:0] addr);
  int unsigned ctx;
  int unsigned idx;
  ctx = addr[regfile_pkg::ADDR_WIDTH-1:regfile_pkg::LOG_REGS];
  idx = addr[regfile_pkg::LOG_REGS-1:0];
  return ctx * regfile_pkg::N_IO_REGS + idx - regfile_pkg::N_MANDATORY_REGS;
endfunction

function automatic void model_write(logic [regfile_pkg::ADDR_WIDTH-1:0] addr,
                                    logic [regfile_pkg::DATA_WIDTH-1:0] data,
                                    logic [regfile_pkg::BE_WIDTH-1:0]   be);
  logic [regfile_pkg::LOG_REGS-1:0] idx;
  int unsigned                      w;
  idx = addr[regfile_pkg::LOG_REGS-1:0];
  if (idx >= regfile_pkg::N_MANDATORY_REGS) begin
    w = store_word(addr);
    for (int b = 0; b < regfile_pkg::BE_WIDTH; b++) begin
      if (be[b])
        mdl_mem[w][b*8 +: 8] = data[b*8 +: 8];
    end
  end else begin
    case (idx)
      regfile_pkg::REG_TRIGGER: begin
        mdl_busy[mdl_acq_ctx] = 1'b1;
        mdl_lock              = 1'b0;
      end
      regfile_pkg::REG_FINISHED:  mdl_finished = 0;
      regfile_pkg::REG_SOFTCLEAR: model_clear();
      default: ;
    endcase
  end
endfunction

// Expected read data and the acquire side effects on lock and id
function automatic logic [31:0] model_read(logic [regfile_pkg::ADDR_WIDTH-1:0] addr);
  logic [regfile_pkg::LOG_REGS-1:0]   idx;
  logic [regfile_pkg::DATA_WIDTH-1:0] val;
  int unsigned                        ptr;
  idx = addr[regfile_pkg::LOG_REGS-1:0];
  val = '0;
  ptr = mdl_job_id % regfile_pkg::N_CONTEXT;
  if (idx >= regfile_pkg::N_MANDATORY_REGS)
    return mdl_mem[store_word(addr)];
  case (idx)
    regfile_pkg::REG_ACQUIRE: begin
      if (mdl_lock) begin
        val = regfile_pkg::RESP_LOCKED;
      end else if (mdl_busy[ptr]) begin
        val = regfile_pkg::RESP_ALL_BUSY;
      end else begin
        val         = mdl_job_id;
        mdl_acq_ctx = ptr;
        mdl_lock    = 1'b1;
        mdl_job_id  = mdl_job_id + 1;
      end
    end
    regfile_pkg::REG_FINISHED: val = mdl_finished;
    regfile_pkg::REG_STATUS: begin
      for (int c = 0; c < regfile_pkg::N_CONTEXT; c++)
        val[c*8 +: 8] = mdl_busy[c]; // Low byte is context 0
    end
    regfile_pkg::REG_RUNNING:                           val = mdl_run_id;
    regfile_pkg::REG_TRIGGER, regfile_pkg::REG_SOFTCLEAR: val = '0;
    default:                                            val = regfile_pkg::RESP_UNMAPPED;
  endcase
  return val;
endfunction

function automatic void model_done();
  mdl_busy[mdl_run_id % regfile_pkg::N_CONTEXT] = 1'b0;
  mdl_run_id = mdl_run_id + 1;
  if (mdl_finished < regfile_pkg::FINISHED_MAX)
    mdl_finished++;
endfunction

`endif

// File: tb_regfile_ctrl.sv
// Register file control testbench
`timescale 1ns/1ps
`default_nettype none

module tb_regfile_ctrl;

  localparam real CLK_PERIOD   = 4.0;
  localparam real DRIVE_DLY    = 1.0;
  localparam int  RESET_CYCLES = 4;
  localparam int  N_PARAM_OPS  = 24;
  localparam int  STIM_CYCLES  = RESET_CYCLES + 2 * N_PARAM_OPS + 110; // Rough sum of all tests
  localparam real WATCHDOG_NS  = STIM_CYCLES * CLK_PERIOD + 100.0;

  logic                                      clk;
  logic                                      rst_n;
  logic                                      req;
  logic                                      wen;
  logic [regfile_pkg::ADDR_WIDTH-1:0]        addr;
  logic [regfile_pkg::DATA_WIDTH-1:0]        wdata;
  logic [regfile_pkg::BE_WIDTH-1:0]          be;
  logic                                      done;
  logic [regfile_pkg::DATA_WIDTH-1:0]        rdata;
  logic [regfile_pkg::N_IO_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] params;
  logic [regfile_pkg::LOG_CONTEXT-1:0]       running_ctx;
  logic                                      busy;

  logic                                      rd_pend;   // Read issued this cycle
  logic [regfile_pkg::DATA_WIDTH-1:0]        rd_exp;
  logic                                      chk_en;    // Read data due this cycle
  logic [regfile_pkg::DATA_WIDTH-1:0]        chk_exp;
  logic                                      state_chk;
  logic [regfile_pkg::N_IO_REGS-1:0][regfile_pkg::DATA_WIDTH-1:0] exp_params;
  logic                                      exp_busy;
  logic [regfile_pkg::LOG_CONTEXT-1:0]       exp_run_ctx;
  string                                     test_name;
  integer                                    seed;

  `include "tb_regfile_ctrl_model.svh"

  regfile_ctrl_top i_dut (
    .clk_i         ( clk         ),
    .rst_ni        ( rst_n       ),
    .req_i         ( req         ),
    .wen_i         ( wen         ),
    .addr_i        ( addr        ),
    .wdata_i       ( wdata       ),
    .be_i          ( be          ),
    .done_i        ( done        ),
    .rdata_o       ( rdata       ),
    .params_o      ( params      ),
    .running_ctx_o ( running_ctx ),
    .busy_o        ( busy        )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2.0) clk = ~clk;
  end

  // Read data returns one cycle after the request
  always @(posedge clk) begin
    chk_en  <= rd_pend;
    chk_exp <= rd_exp;
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  rdata_check: assert property (@(posedge clk) disable iff (!rst_n) chk_en |-> rdata == chk_exp)
    else stop_with_failure($sformatf("mismatch in %s: rdata_o expected %h actual %h",
                                     test_name, $sampled(chk_exp), $sampled(rdata)));
  params_check: assert property (@(posedge clk) disable iff (!rst_n)
                                 state_chk |-> params == exp_params)
    else stop_with_failure($sformatf("mismatch in %s: params_o expected %h actual %h",
                                     test_name, $sampled(exp_params), $sampled(params)));
  busy_check: assert property (@(posedge clk) disable iff (!rst_n) state_chk |-> busy == exp_busy)
    else stop_with_failure($sformatf("mismatch in %s: busy_o expected %h actual %h",
                                     test_name, $sampled(exp_busy), $sampled(busy)));
  ctx_check: assert property (@(posedge clk) disable iff (!rst_n)
                              state_chk |-> running_ctx == exp_run_ctx)
    else stop_with_failure($sformatf("mismatch in %s: running_ctx_o expected %h actual %h",
                                     test_name, $sampled(exp_run_ctx), $sampled(running_ctx)));

  function automatic logic [regfile_pkg::ADDR_WIDTH-1:0] reg_addr(int unsigned ctx,
                                                                  int unsigned idx);
    logic [regfile_pkg::ADDR_WIDTH-1:0] a;
    a[regfile_pkg::LOG_REGS-1:0]                       = idx;
    a[regfile_pkg::ADDR_WIDTH-1:regfile_pkg::LOG_REGS] = ctx % regfile_pkg::N_CONTEXT;
    return a;
  endfunction

  function automatic logic [regfile_pkg::ADDR_WIDTH-1:0] param_addr(int unsigned ctx,
                                                                    int unsigned word);
    return reg_addr(ctx, regfile_pkg::N_MANDATORY_REGS + word % regfile_pkg::N_IO_REGS);
  endfunction

  // Every bus cycle starts just after the rising edge with the bus idle
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    req       = 1'b0;
    wen       = 1'b0;
    done      = 1'b0;
    rd_pend   = 1'b0;
    state_chk = 1'b0;
  endtask

  task automatic bus_write(input logic [regfile_pkg::ADDR_WIDTH-1:0] a,
                           input logic [regfile_pkg::DATA_WIDTH-1:0] d,
                           input logic [regfile_pkg::BE_WIDTH-1:0]   b);
    next_cycle();
    req   = 1'b1;
    wen   = 1'b1;
    addr  = a;
    wdata = d;
    be    = b;
    model_write(a, d, b);
    if (a[regfile_pkg::LOG_REGS-1:0] < regfile_pkg::N_MANDATORY_REGS)
      next_cycle(); // Strobe lands one cycle later
  endtask

  task automatic bus_read(input logic [regfile_pkg::ADDR_WIDTH-1:0] a);
    next_cycle();
    req     = 1'b1;
    addr    = a;
    rd_pend = 1'b1;
    rd_exp  = model_read(a);
  endtask

  task automatic pulse_done();
    next_cycle();
    done = 1'b1;
    model_done();
  endtask

  task automatic check_state();
    next_cycle();
    state_chk = 1'b1;
    exp_busy  = 1'b0;
    for (int w = 0; w < regfile_pkg::N_IO_REGS; w++)
      exp_params[w] = mdl_mem[(mdl_run_id % regfile_pkg::N_CONTEXT) * regfile_pkg::N_IO_REGS + w];
    foreach (mdl_busy[c])
      exp_busy = exp_busy | mdl_busy[c];
    exp_run_ctx = mdl_run_id % regfile_pkg::N_CONTEXT;
  endtask

  task automatic start_test(input string name);
    next_cycle();
    next_cycle(); // Last read check of the previous test retires
    test_name = name;
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("timeout: the stimulus did not finish within the expected time");
  end

  initial begin
    logic [regfile_pkg::ADDR_WIDTH-1:0] a;
    logic [regfile_pkg::DATA_WIDTH-1:0] d;
    logic [regfile_pkg::BE_WIDTH-1:0]   b;
    seed      = 51915;
    rst_n     = 1'b0;
    req       = 1'b0;
    wen       = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    done      = 1'b0;
    rd_pend   = 1'b0;
    rd_exp    = '0;
    state_chk = 1'b0;
    test_name = "reset";
    model_clear();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    start_test("parameters");
    for (int i = 0; i < N_PARAM_OPS; i++) begin
      a = param_addr($random(seed), $random(seed));
      d = $random(seed);
      b = $random(seed);
      bus_write(a, d, b);
      bus_read(a);
    end
    for (int w = 0; w < regfile_pkg::N_CONTEXT * regfile_pkg::N_IO_REGS; w++)
      bus_read(param_addr(w / regfile_pkg::N_IO_REGS, w)); // Back-to-back reads
    check_state();

    start_test("acquire");
    bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE));
    bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE)); // Still locked
    bus_write(reg_addr(0, regfile_pkg::REG_TRIGGER), '0, '1);
    bus_read(reg_addr(0, regfile_pkg::REG_STATUS));
    check_state();

    start_test("contexts_full");
    for (int c = 1; c < regfile_pkg::N_CONTEXT; c++) begin
      bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE));
      bus_write(reg_addr(0, regfile_pkg::REG_TRIGGER), '0, '1);
    end
    bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE));
    bus_read(reg_addr(0, regfile_pkg::REG_STATUS));
    check_state();

    start_test("done");
    pulse_done();
    bus_read(reg_addr(0, regfile_pkg::REG_STATUS));
    bus_read(reg_addr(0, regfile_pkg::REG_RUNNING));
    check_state();
    pulse_done();
    pulse_done(); // Counter saturates here
    bus_read(reg_addr(0, regfile_pkg::REG_FINISHED));
    bus_write(reg_addr(0, regfile_pkg::REG_FINISHED), '0, '1);
    bus_read(reg_addr(0, regfile_pkg::REG_FINISHED));
    check_state();

    start_test("unmapped_softclear");
    for (int i = regfile_pkg::REG_SOFTCLEAR + 1; i < regfile_pkg::N_MANDATORY_REGS; i++) begin
      bus_read(reg_addr(0, i));
      bus_read(reg_addr(1, i));
    end
    bus_read(reg_addr(0, regfile_pkg::REG_TRIGGER));
    bus_read(reg_addr(0, regfile_pkg::REG_SOFTCLEAR));
    bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE));
    bus_write(reg_addr(0, regfile_pkg::REG_TRIGGER), '0, '1);
    bus_write(param_addr(1, 2), $random(seed), '1);
    bus_write(reg_addr(0, regfile_pkg::REG_SOFTCLEAR), '0, '1);
    for (int i = 0; i < regfile_pkg::N_MANDATORY_REGS; i++) begin
      if (i != regfile_pkg::REG_ACQUIRE)
        bus_read(reg_addr(0, i));
    end
    for (int w = 0; w < regfile_pkg::N_CONTEXT * regfile_pkg::N_IO_REGS; w++)
      bus_read(param_addr(w / regfile_pkg::N_IO_REGS, w));
    check_state();
    bus_read(reg_addr(0, regfile_pkg::REG_ACQUIRE)); // Id restarts from zero

    start_test("end");
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
regfile_pkg.sv
regfile_access_decode.sv
regfile_param_store.sv
regfile_job_tracker.sv
regfile_ctrl_top.sv
tb_regfile_ctrl.sv
